// ==== source/gcode_macros.svh ====
`ifndef GCODE_MACROS_SVH
`define GCODE_MACROS_SVH

// widths
`define BYTE_BITS 8
`define COORD_BITS 24 // signed, in tenths of a unit
`define FIFO_DEPTH 64

// character codes seen in a motion line
`define ASCII_NL 8'h0A
`define ASCII_SP 8'h20
`define ASCII_DOT 8'h2E
`define ASCII_MINUS 8'h2D
`define ASCII_ZERO 8'h30
`define ASCII_NINE 8'h39

// word letters
`define ASCII_G 8'h47
`define ASCII_X 8'h58
`define ASCII_Y 8'h59
`define ASCII_I 8'h49
`define ASCII_J 8'h4A

`endif

// ==== source/motion_pkg.sv ====
`include "gcode_macros.svh"

package motion_pkg;

	// coordinates are kept in tenths, so 10.2 is stored as 102
	typedef logic signed [`COORD_BITS-1:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

endpackage

// ==== source/gcode_pkg.sv ====
package gcode_pkg;

	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_G00 = 3'd1,
		OP_G01 = 3'd2,
		OP_G02 = 3'd3,
		OP_G03 = 3'd4
	} op_cmd_e;

	// one bit per argument letter
	typedef logic [3:0] arg_flags_t;

	localparam int FLAG_X = 0;
	localparam int FLAG_Y = 1;
	localparam int FLAG_I = 2;
	localparam int FLAG_J = 3;

	localparam arg_flags_t ARGS_LINEAR = 4'b0011; // X, Y
	localparam arg_flags_t ARGS_CIRCULAR = 4'b1111; // X, Y, I, J

	typedef struct packed {
		op_cmd_e cmd;
		motion_pkg::coord_t arg_1; // X
		motion_pkg::coord_t arg_2; // Y
		motion_pkg::coord_t arg_3; // I
		motion_pkg::coord_t arg_4; // J
		arg_flags_t flags;
		logic success;
	} op_t;

endpackage

// ==== source/char_bus_if.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

interface char_bus_if;
	logic req;
	logic gnt;
	logic rd_trigger;
	logic rd_done;
	logic [`BYTE_BITS-1:0] rd_data;
	logic is_empty;

	modport requester (
		output req,
		output rd_trigger,
		input gnt,
		input rd_done,
		input rd_data,
		input is_empty
	);

	modport arbiter (
		input req,
		input rd_trigger,
		output gnt,
		output rd_done,
		output rd_data,
		output is_empty
	);
endinterface

// ==== source/char_fifo.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module char_fifo (
	input logic sub_intf,
	input logic rst_n,
	input logic wr_valid,
	input logic [`BYTE_BITS-1:0] wr_data,
	input logic rd_trigger,
	output logic [`BYTE_BITS-1:0] rd_data,
	output logic rd_done,
	output logic is_empty,
	output logic is_full
);
	localparam int AW = $clog2(`FIFO_DEPTH);

	logic [`BYTE_BITS-1:0] mem [`FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	assign is_empty = (count == '0);
	assign is_full = (count == (AW+1)'(`FIFO_DEPTH));
	assign do_wr = wr_valid && !is_full; // writes into a full buffer are dropped
	assign do_rd = rd_trigger && !is_empty;

	always_ff @(posedge sub_intf) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rd_done <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
			rd_done <= do_rd;
		end
	end

	always_ff @(posedge sub_intf) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
		if (do_rd)
			rd_data <= mem[rd_ptr];
	end

	// requesters only trigger when they see data
	a_no_empty_read: assert property (@(posedge sub_intf) disable iff (!rst_n)
		rd_trigger |-> !is_empty);

endmodule

// ==== source/fifo_arbiter.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module fifo_arbiter (
	input logic sub_intf,
	input logic rst_n,
	char_bus_if.arbiter cmd_bus,
	char_bus_if.arbiter lin_bus,
	char_bus_if.arbiter arc_bus,
	output logic rd_trigger,
	input logic [`BYTE_BITS-1:0] rd_data,
	input logic rd_done,
	input logic is_empty
);
	logic [2:0] reqs;
	logic [2:0] trigs;
	logic [2:0] gnt_q; // one-hot, index 0 cmd, 1 lin, 2 arc

	assign reqs = {arc_bus.req, lin_bus.req, cmd_bus.req};
	assign trigs = {arc_bus.rd_trigger, lin_bus.rd_trigger, cmd_bus.rd_trigger};

	always_ff @(posedge sub_intf) begin
		if (!rst_n)
			gnt_q <= 3'b000;
		else if ((gnt_q & reqs) == 3'b000)
			gnt_q <= reqs & (~reqs + 3'd1); // lowest set request wins
	end

	assign cmd_bus.gnt = gnt_q[0];
	assign lin_bus.gnt = gnt_q[1];
	assign arc_bus.gnt = gnt_q[2];

	assign rd_trigger = |(trigs & gnt_q);

	// only the owner hears completions; the others see an empty port
	assign cmd_bus.rd_done = rd_done && gnt_q[0];
	assign lin_bus.rd_done = rd_done && gnt_q[1];
	assign arc_bus.rd_done = rd_done && gnt_q[2];
	assign cmd_bus.is_empty = is_empty || !gnt_q[0];
	assign lin_bus.is_empty = is_empty || !gnt_q[1];
	assign arc_bus.is_empty = is_empty || !gnt_q[2];

	assign cmd_bus.rd_data = rd_data;
	assign lin_bus.rd_data = rd_data;
	assign arc_bus.rd_data = rd_data;

	a_one_grant: assert property (@(posedge sub_intf) disable iff (!rst_n)
		$onehot0(gnt_q));
	a_trigger_granted: assert property (@(posedge sub_intf) disable iff (!rst_n)
		(trigs & ~gnt_q) == 3'b000);

endmodule

// ==== source/command_reader.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module command_reader (
	input logic sub_intf,
	input logic rst_n,
	char_bus_if.requester bus,
	output logic lin_start,
	output logic arc_start,
	output gcode_pkg::op_cmd_e start_cmd,
	output logic fail_done,
	output gcode_pkg::op_t fail_op,
	input logic commit_done
);
	typedef enum logic [2:0] {
		ST_IDLE, ST_G, ST_D1, ST_D2, ST_DRAIN, ST_REPORT, ST_WAIT
	} state_e;

	state_e state;
	logic pending; // read issued, byte not back yet
	logic tens_zero;
	logic reading;
	logic is_digit;
	logic [`BYTE_BITS-1:0] ch;
	logic [3:0] units;

	assign ch = bus.rd_data;
	assign is_digit = (ch >= `ASCII_ZERO) && (ch <= `ASCII_NINE);
	assign units = ch[3:0];
	assign reading = (state == ST_G) || (state == ST_D1) || (state == ST_D2) ||
		(state == ST_DRAIN);

	assign bus.req = reading;
	assign bus.rd_trigger = reading && bus.gnt && !pending && !bus.is_empty;

	always_comb begin
		fail_op = '0;
		fail_op.cmd = gcode_pkg::OP_NONE;
	end

	always_ff @(posedge sub_intf) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pending <= 1'b0;
			tens_zero <= 1'b0;
			lin_start <= 1'b0;
			arc_start <= 1'b0;
			fail_done <= 1'b0;
			start_cmd <= gcode_pkg::OP_NONE;
		end else begin
			lin_start <= 1'b0;
			arc_start <= 1'b0;
			fail_done <= 1'b0;
			if (bus.rd_done)
				pending <= 1'b0;
			else if (bus.rd_trigger)
				pending <= 1'b1;

			case (state)
				ST_IDLE: state <= ST_G;
				ST_G: if (bus.rd_done) begin
					if (ch == `ASCII_G)
						state <= ST_D1;
					else if (ch != `ASCII_SP && ch != `ASCII_NL) // blank lines skipped
						state <= ST_DRAIN;
				end
				ST_D1: if (bus.rd_done) begin
					tens_zero <= (ch == `ASCII_ZERO);
					if (is_digit)
						state <= ST_D2;
					else
						state <= (ch == `ASCII_NL) ? ST_REPORT : ST_DRAIN;
				end
				ST_D2: if (bus.rd_done) begin
					if (is_digit && tens_zero && units <= 4'd3) begin
						start_cmd <= gcode_pkg::op_cmd_e'(units[2:0] + 3'd1);
						lin_start <= (units < 4'd2); // G00/G01
						arc_start <= (units >= 4'd2); // G02/G03
						state <= ST_WAIT;
					end else begin
						state <= (ch == `ASCII_NL) ? ST_REPORT : ST_DRAIN;
					end
				end
				ST_DRAIN: if (bus.rd_done && ch == `ASCII_NL)
					state <= ST_REPORT;
				ST_REPORT: begin
					fail_done <= 1'b1;
					state <= ST_WAIT;
				end
				ST_WAIT: if (commit_done)
					state <= ST_G;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== source/word_subparser.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module word_subparser #(
	parameter gcode_pkg::arg_flags_t ALLOWED = gcode_pkg::ARGS_LINEAR
) (
	input logic sub_intf,
	input logic rst_n,
	input logic start,
	input gcode_pkg::op_cmd_e start_cmd,
	char_bus_if.requester bus,
	input motion_pkg::pos_t cur_pos,
	output logic done,
	output gcode_pkg::op_t op
);
	typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_NUM, ST_FINISH} state_e;

	state_e state;
	logic pending;
	gcode_pkg::op_cmd_e cmd_q;
	motion_pkg::coord_t args [4];
	gcode_pkg::arg_flags_t flags;
	logic ok;
	logic [1:0] sel; // letter of the word being read
	logic neg;
	logic in_frac;
	logic frac_taken;
	logic got_digit;
	logic [`COORD_BITS-1:0] int_acc;
	logic [3:0] frac_digit;
	logic [`BYTE_BITS-1:0] ch;
	logic is_digit;
	logic is_letter;
	logic [1:0] letter_idx;
	logic lead_space;
	logic [`COORD_BITS-1:0] magnitude;
	motion_pkg::coord_t word_val;
	logic arc_ok;

	assign ch = bus.rd_data;
	assign is_digit = (ch >= `ASCII_ZERO) && (ch <= `ASCII_NINE);
	assign lead_space = (ch == `ASCII_SP) && !got_digit && !neg && !in_frac;

	always_comb begin
		is_letter = 1'b1;
		letter_idx = 2'd0;
		case (ch)
			`ASCII_X: letter_idx = 2'(gcode_pkg::FLAG_X);
			`ASCII_Y: letter_idx = 2'(gcode_pkg::FLAG_Y);
			`ASCII_I: letter_idx = 2'(gcode_pkg::FLAG_I);
			`ASCII_J: letter_idx = 2'(gcode_pkg::FLAG_J);
			default: is_letter = 1'b0;
		endcase
	end

	// tenths: integer part times ten plus the first fractional digit
	assign magnitude = int_acc * `COORD_BITS'(10) + `COORD_BITS'(frac_digit);
	assign word_val = neg ? -motion_pkg::coord_t'(magnitude) : motion_pkg::coord_t'(magnitude);

	// an arc needs a center offset
	assign arc_ok = !(ALLOWED[gcode_pkg::FLAG_I] && ALLOWED[gcode_pkg::FLAG_J]) ||
		flags[gcode_pkg::FLAG_I] || flags[gcode_pkg::FLAG_J];

	assign bus.req = (state == ST_SCAN) || (state == ST_NUM);
	assign bus.rd_trigger = bus.req && bus.gnt && !pending && !bus.is_empty;

	always_ff @(posedge sub_intf) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			pending <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (bus.rd_done)
				pending <= 1'b0;
			else if (bus.rd_trigger)
				pending <= 1'b1;

			case (state)
				ST_IDLE: if (start) begin
					cmd_q <= start_cmd;
					flags <= '0;
					ok <= 1'b1;
					for (int k = 0; k < 4; k++)
						args[k] <= '0; // missing I/J read as zero
					state <= ST_SCAN;
				end
				ST_SCAN: if (bus.rd_done) begin
					if (ch == `ASCII_NL) begin
						state <= ST_FINISH;
					end else if (is_letter) begin
						sel <= letter_idx;
						neg <= 1'b0;
						in_frac <= 1'b0;
						frac_taken <= 1'b0;
						got_digit <= 1'b0;
						int_acc <= '0;
						frac_digit <= '0;
						if (!ALLOWED[letter_idx])
							ok <= 1'b0;
						state <= ST_NUM;
					end else if (ch != `ASCII_SP) begin
						ok <= 1'b0; // stray character
					end
				end
				ST_NUM: if (bus.rd_done) begin
					if (is_digit) begin
						got_digit <= 1'b1;
						if (!in_frac) begin
							int_acc <= int_acc * `COORD_BITS'(10) + `COORD_BITS'(ch[3:0]);
						end else if (!frac_taken) begin
							frac_digit <= ch[3:0];
							frac_taken <= 1'b1; // later digits dropped
						end
					end else if (ch == `ASCII_DOT && !in_frac) begin
						in_frac <= 1'b1;
					end else if (ch == `ASCII_MINUS && !got_digit && !neg && !in_frac) begin
						neg <= 1'b1;
					end else if (!lead_space) begin
						args[sel] <= word_val;
						flags[sel] <= 1'b1;
						if (!got_digit)
							ok <= 1'b0;
						if (ch == `ASCII_NL) begin
							state <= ST_FINISH;
						end else if (is_letter) begin
							sel <= letter_idx; // next word follows directly
							neg <= 1'b0;
							in_frac <= 1'b0;
							frac_taken <= 1'b0;
							got_digit <= 1'b0;
							int_acc <= '0;
							frac_digit <= '0;
							if (!ALLOWED[letter_idx])
								ok <= 1'b0;
						end else begin
							if (ch != `ASCII_SP)
								ok <= 1'b0;
							state <= ST_SCAN;
						end
					end
				end
				ST_FINISH: begin
					done <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sub_intf) begin
		if (state == ST_FINISH) begin
			op.cmd <= cmd_q;
			op.arg_1 <= flags[gcode_pkg::FLAG_X] ? args[0] : cur_pos.x;
			op.arg_2 <= flags[gcode_pkg::FLAG_Y] ? args[1] : cur_pos.y;
			op.arg_3 <= args[2];
			op.arg_4 <= args[3];
			op.flags <= flags;
			op.success <= ok && arc_ok;
		end
	end

	a_start_idle: assert property (@(posedge sub_intf) disable iff (!rst_n)
		start |-> state == ST_IDLE);

endmodule

// ==== source/op_commit.sv ====
`timescale 1ns/1ps

module op_commit (
	input logic sub_intf,
	input logic rst_n,
	input logic lin_done,
	input gcode_pkg::op_t lin_op,
	input logic arc_done,
	input gcode_pkg::op_t arc_op,
	input logic fail_done,
	input gcode_pkg::op_t fail_op,
	output logic commit_done,
	output logic op_valid,
	output gcode_pkg::op_t op,
	output motion_pkg::pos_t cur_pos
);
	logic any_done;
	gcode_pkg::op_t sel_op;

	assign any_done = lin_done || arc_done || fail_done;

	always_comb begin
		sel_op = fail_op;
		if (lin_done)
			sel_op = lin_op;
		else if (arc_done)
			sel_op = arc_op;
	end

	always_ff @(posedge sub_intf) begin
		if (!rst_n) begin
			op_valid <= 1'b0;
			cur_pos <= '0;
		end else begin
			op_valid <= any_done;
			if (any_done && sel_op.success) begin // failed ops do not move
				cur_pos.x <= sel_op.arg_1;
				cur_pos.y <= sel_op.arg_2;
			end
		end
	end

	always_ff @(posedge sub_intf) begin
		if (any_done)
			op <= sel_op;
	end

	// releases the command reader for the next line
	assign commit_done = op_valid;

	a_one_done: assert property (@(posedge sub_intf) disable iff (!rst_n)
		$onehot0({lin_done, arc_done, fail_done}));

endmodule

// ==== source/gcode_top.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module gcode_top (
	input logic sub_intf,
	input logic rst_n,
	input logic load_valid,
	input logic [`BYTE_BITS-1:0] load_char,
	output logic fifo_full,
	output logic op_valid,
	output gcode_pkg::op_cmd_e op_cmd,
	output motion_pkg::coord_t op_x,
	output motion_pkg::coord_t op_y,
	output motion_pkg::coord_t op_i,
	output motion_pkg::coord_t op_j,
	output gcode_pkg::arg_flags_t op_flags,
	output logic op_success,
	output motion_pkg::coord_t cur_x,
	output motion_pkg::coord_t cur_y
);
	logic rd_trigger;
	logic [`BYTE_BITS-1:0] rd_data;
	logic rd_done;
	logic is_empty;
	logic lin_start;
	logic arc_start;
	gcode_pkg::op_cmd_e start_cmd;
	logic lin_done;
	logic arc_done;
	logic fail_done;
	logic commit_done;
	gcode_pkg::op_t lin_op;
	gcode_pkg::op_t arc_op;
	gcode_pkg::op_t fail_op;
	gcode_pkg::op_t op;
	motion_pkg::pos_t cur_pos;

	char_bus_if cmd_bus ();
	char_bus_if lin_bus ();
	char_bus_if arc_bus ();

	char_fifo fifo0 (
		.sub_intf(sub_intf), .rst_n(rst_n),
		.wr_valid(load_valid), .wr_data(load_char),
		.rd_trigger(rd_trigger), .rd_data(rd_data), .rd_done(rd_done),
		.is_empty(is_empty), .is_full(fifo_full)
	);

	fifo_arbiter arb0 (
		.sub_intf(sub_intf), .rst_n(rst_n),
		.cmd_bus(cmd_bus.arbiter), .lin_bus(lin_bus.arbiter), .arc_bus(arc_bus.arbiter),
		.rd_trigger(rd_trigger), .rd_data(rd_data), .rd_done(rd_done), .is_empty(is_empty)
	);

	command_reader cmd_reader (
		.sub_intf(sub_intf), .rst_n(rst_n), .bus(cmd_bus.requester),
		.lin_start(lin_start), .arc_start(arc_start), .start_cmd(start_cmd),
		.fail_done(fail_done), .fail_op(fail_op), .commit_done(commit_done)
	);

	word_subparser #(.ALLOWED(gcode_pkg::ARGS_LINEAR)) lin_parser (
		.sub_intf(sub_intf), .rst_n(rst_n), .start(lin_start), .start_cmd(start_cmd),
		.bus(lin_bus.requester), .cur_pos(cur_pos), .done(lin_done), .op(lin_op)
	);

	word_subparser #(.ALLOWED(gcode_pkg::ARGS_CIRCULAR)) arc_parser (
		.sub_intf(sub_intf), .rst_n(rst_n), .start(arc_start), .start_cmd(start_cmd),
		.bus(arc_bus.requester), .cur_pos(cur_pos), .done(arc_done), .op(arc_op)
	);

	op_commit commit0 (
		.sub_intf(sub_intf), .rst_n(rst_n),
		.lin_done(lin_done), .lin_op(lin_op), .arc_done(arc_done), .arc_op(arc_op),
		.fail_done(fail_done), .fail_op(fail_op), .commit_done(commit_done),
		.op_valid(op_valid), .op(op), .cur_pos(cur_pos)
	);

	assign op_cmd = op.cmd;
	assign op_x = op.arg_1;
	assign op_y = op.arg_2;
	assign op_i = op.arg_3;
	assign op_j = op.arg_4;
	assign op_flags = op.flags;
	assign op_success = op.success;
	assign cur_x = cur_pos.x;
	assign cur_y = cur_pos.y;

endmodule

// ==== bench/gcode_tb.sv ====
`timescale 1ns/1ps
`include "gcode_macros.svh"

module gcode_tb;

	localparam int OP_LIMIT = 2000; // cycles allowed per op
	localparam int FULL_LIMIT = 500; // cycles the loader may stall on fifo_full
	localparam int BURST_LINES = 30;

	typedef struct {
		string text;
		int gap; // 0 none, 1 short random gaps, 2 long gaps mid-line
		gcode_pkg::op_cmd_e cmd;
		int x;
		int y;
		int i;
		int j;
		logic [3:0] flags;
		bit success;
		int pos_x;
		int pos_y;
	} row_t;

	logic sub_intf;
	logic rst_n;
	logic load_valid;
	logic [`BYTE_BITS-1:0] load_char;
	logic fifo_full;
	logic op_valid;
	gcode_pkg::op_cmd_e op_cmd;
	motion_pkg::coord_t op_x;
	motion_pkg::coord_t op_y;
	motion_pkg::coord_t op_i;
	motion_pkg::coord_t op_j;
	gcode_pkg::arg_flags_t op_flags;
	logic op_success;
	motion_pkg::coord_t cur_x;
	motion_pkg::coord_t cur_y;

	row_t rows[$];
	integer seed = 32'h9e7f;
	int errors = 0;
	int checks = 0;
	int op_count = 0;
	bit saw_full = 1'b0;
	bit abort = 1'b0;

	gcode_top dut0 (
		.sub_intf(sub_intf), .rst_n(rst_n), .load_valid(load_valid), .load_char(load_char),
		.fifo_full(fifo_full), .op_valid(op_valid), .op_cmd(op_cmd),
		.op_x(op_x), .op_y(op_y), .op_i(op_i), .op_j(op_j),
		.op_flags(op_flags), .op_success(op_success), .cur_x(cur_x), .cur_y(cur_y)
	);

	initial sub_intf = 1'b0;
	always #2 sub_intf = ~sub_intf;

	// pulse counter and full flag, sampled where outputs are stable
	always @(negedge sub_intf) begin
		if (rst_n && op_valid)
			op_count++;
		if (rst_n && fifo_full)
			saw_full = 1'b1;
	end

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic add_row(input string text, input int gap, input gcode_pkg::op_cmd_e cmd,
		input int x, input int y, input int i, input int j, input logic [3:0] flags,
		input bit success, input int pos_x, input int pos_y);
		row_t e;
		e.text = text;
		e.gap = gap;
		e.cmd = cmd;
		e.x = x;
		e.y = y;
		e.i = i;
		e.j = j;
		e.flags = flags;
		e.success = success;
		e.pos_x = pos_x;
		e.pos_y = pos_y;
		rows.push_back(e);
	endtask

	task automatic idle(input int n);
		load_valid = 1'b0;
		repeat (n) @(negedge sub_intf);
	endtask

	task automatic send_byte(input logic [`BYTE_BITS-1:0] c);
		int waited;
		waited = 0;
		while (fifo_full && !abort) begin
			load_valid = 1'b0;
			waited++;
			if (waited > FULL_LIMIT) begin
				errors++;
				abort = 1'b1;
				$display("loader stuck: fifo_full stayed high for %0d cycles", waited);
			end
			@(negedge sub_intf);
		end
		if (!abort) begin
			load_valid = 1'b1;
			load_char = c;
			@(negedge sub_intf);
		end
		load_valid = 1'b0;
	endtask

	task automatic load_line(input int r);
		row_t e;
		e = rows[r];
		for (int b = 0; b < e.text.len() && !abort; b++) begin
			if (e.gap == 1)
				idle($random(seed) & 3);
			else if (e.gap == 2 && b % 4 == 3)
				idle(24 + ($random(seed) & 31)); // long enough to empty the FIFO
			send_byte(e.text[b]);
		end
	endtask

	task automatic wait_op(input int r);
		int waited;
		waited = 0;
		@(negedge sub_intf);
		while (!op_valid && !abort) begin
			waited++;
			if (waited > OP_LIMIT) begin
				errors++;
				abort = 1'b1;
				$display("op_valid for line %0d did not arrive within %0d cycles", r, OP_LIMIT);
			end
			@(negedge sub_intf);
		end
	endtask

	task automatic compare_row(input int r);
		row_t e;
		string tag;
		e = rows[r];
		tag = $sformatf(" (line %0d)", r);
		check_value({"op_cmd", tag}, int'(e.cmd), int'(op_cmd));
		check_value({"op_x", tag}, e.x, int'(op_x));
		check_value({"op_y", tag}, e.y, int'(op_y));
		check_value({"op_i", tag}, e.i, int'(op_i));
		check_value({"op_j", tag}, e.j, int'(op_j));
		check_value({"op_flags", tag}, int'(e.flags), int'(op_flags));
		check_value({"op_success", tag}, int'(e.success), int'(op_success));
		check_value({"cur_x", tag}, e.pos_x, int'(cur_x));
		check_value({"cur_y", tag}, e.pos_y, int'(cur_y));
	endtask

	initial begin
		rst_n = 1'b0;
		load_valid = 1'b0;
		load_char = '0;

		// text, gap, cmd, x, y, i, j, flags (JIYX), success, position after the line
		add_row("G00 X5 Y5\n", 0, gcode_pkg::OP_G00, 50, 50, 0, 0, 4'b0011, 1'b1, 50, 50);
		add_row("G03 X10.2 Y-5.1 I3.75 J-2\n", 0, gcode_pkg::OP_G03,
			102, -51, 37, -20, 4'b1111, 1'b1, 102, -51);
		add_row("G01 X7\n", 0, gcode_pkg::OP_G01, 70, -51, 0, 0, 4'b0001, 1'b1, 70, -51);
		add_row("G02 X1 Y2\n", 0, gcode_pkg::OP_G02, 10, 20, 0, 0, 4'b0011, 1'b0, 70, -51);
		add_row("G00 X1 I2\n", 0, gcode_pkg::OP_G00, 10, -51, 20, 0, 4'b0101, 1'b0, 70, -51);
		add_row("G01 Y3\n", 0, gcode_pkg::OP_G01, 70, 30, 0, 0, 4'b0010, 1'b1, 70, 30);
		add_row("G17 X1\n", 0, gcode_pkg::OP_NONE, 0, 0, 0, 0, 4'b0000, 1'b0, 70, 30);
		add_row("G00 X-2.5 Y0.06\n", 0, gcode_pkg::OP_G00, -25, 0, 0, 0, 4'b0011, 1'b1, -25, 0);
		add_row("G01 X4 $\n", 0, gcode_pkg::OP_G01, 40, 0, 0, 0, 4'b0001, 1'b0, -25, 0);
		add_row("G02 X3 Y4 J1.5\n", 2, gcode_pkg::OP_G02, 30, 40, 0, 15, 4'b1011, 1'b1, 30, 40);
		add_row("G03 X-1 I-0.5\n", 2, gcode_pkg::OP_G03, -10, 40, -5, 0, 4'b0101, 1'b1, -10, 40);
		add_row("G01 X2.2 Y-3.3\n", 1, gcode_pkg::OP_G01, 22, -33, 0, 0, 4'b0011, 1'b1, 22, -33);
		add_row("G03 X10.2 Y-5.1 I3.75 J-2\n", 2, gcode_pkg::OP_G03,
			102, -51, 37, -20, 4'b1111, 1'b1, 102, -51);
		// back to back burst, loads faster than the parser reads
		for (int k = 1; k <= BURST_LINES; k++)
			add_row($sformatf("G01 X%0d.%0d Y-%0d\n", k, k % 10, k), 0, gcode_pkg::OP_G01,
				k * 10 + k % 10, -k * 10, 0, 0, 4'b0011, 1'b1, k * 10 + k % 10, -k * 10);

		repeat (16) @(negedge sub_intf);
		rst_n = 1'b1;

		fork
			begin
				for (int r = 0; r < rows.size() && !abort; r++)
					load_line(r);
				load_valid = 1'b0;
			end
			begin
				for (int r = 0; r < rows.size() && !abort; r++) begin
					wait_op(r);
					if (!abort)
						compare_row(r);
				end
			end
		join

		idle(40); // catch any extra op pulses
		check_value("op_valid count", rows.size(), op_count);
		if (!saw_full) begin
			errors++;
			$display("fifo_full never rose while the burst of short lines was loaded");
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== gcode_arc.f ====
+incdir+source
source/motion_pkg.sv
source/gcode_pkg.sv
source/char_bus_if.sv
source/char_fifo.sv
source/fifo_arbiter.sv
source/command_reader.sv
source/word_subparser.sv
source/op_commit.sv
source/gcode_top.sv
bench/gcode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
	--top-module gcode_tb -Mdir obj_dir -f gcode_arc.f &&
./obj_dir/Vgcode_tb | tee /dev/stderr | grep -qF "TEST RESULT: PASS" &&
echo "simulation passed" ||
{
	echo "simulation failed"
	exit 1
}
